//--- source/sd_pkg.sv
// SD card controller definitions
package sd_pkg;

    // Command indices used during card bring-up
    typedef enum logic [5:0] {
        CMD0   = 6'd0,
        CMD2   = 6'd2,
        CMD3   = 6'd3,
        CMD8   = 6'd8,
        ACMD41 = 6'd41,
        CMD55  = 6'd55
    } sd_cmd_e;

    // Expected response format
    typedef enum logic [2:0] {R1, R2, R3, R6, R7} sd_rsp_e;

    // Card state as seen by the host
    typedef enum logic [2:0] {
        SDSTATE_PRE_INIT,
        SDSTATE_IDLE,
        SDSTATE_READY,
        SDSTATE_IDENT,
        SDSTATE_STBY,
        SDSTATE_INA
    } sd_state_e;

    // Steps inside the idle state
    typedef enum logic [2:0] {
        IDLE_CMD0,
        IDLE_CMD8,
        IDLE_CMD55,
        IDLE_ACMD41,
        IDLE_CARD_ID
    } sd_idle_e;

    typedef enum logic [2:0] {
        SDCARD_UNKNOWN,
        SDCARD_VER1X,
        SDCARD_VER2X_SC,
        SDCARD_VER2X_HC,
        SDCARD_UNUSABLE
    } sd_type_e;

    typedef enum logic [1:0] {
        CMDERR_NONE,
        CMDERR_NO_RESPONSE,
        CMDERR_BAD_CRC,
        CMDERR_BAD_INDEX
    } sd_cmderr_e;

    typedef struct packed {
        sd_cmd_e     cmd;
        logic [31:0] arg;
        sd_rsp_e     rsp;
    } sd_cmd_req_t;

    typedef struct packed {
        logic [5:0]  index;
        // Card status, OCR, or bits 39..8 of an R2 frame
        logic [31:0] regval;
        sd_cmderr_e  err;
        // Low while the card is still busy (register bit 31)
        logic        busy_n;
        logic [1:0]  spare;
    } sd_cmd_rsp_t;

    localparam int SD_PREINIT_CLKS = 74;
    localparam int SD_CMD_BITS     = 48;
    localparam int SD_R2_BITS      = 136;

endpackage

//--- source/sd_clk_gen.sv
// SD clock divider
`timescale 1ns/1ps

module sd_clk_gen #(
    parameter int CLK_DIV = 2
) (
    input  logic i_clk,
    input  logic i_nrst,
    output logic o_sclk,
    output logic o_sclk_rise,
    output logic o_sclk_fall
);

    localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [CW-1:0] div_cnt;
    logic          half_done;

    // Last i_clk cycle of the current half period
    assign half_done = (div_cnt == CW'(CLK_DIV - 1));

    // Strobes mark the cycle whose closing edge moves o_sclk
    assign o_sclk_rise = half_done && !o_sclk;
    assign o_sclk_fall = half_done && o_sclk;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            div_cnt <= '0;
            o_sclk  <= 1'b0;
        end else if (half_done) begin
            div_cnt <= '0;
            o_sclk  <= ~o_sclk;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

//--- source/sd_crc7.sv
// CRC7 for the command line
`timescale 1ns/1ps

module sd_crc7 (
    input  logic       i_clk,
    input  logic       i_nrst,
    input  logic       i_clear,
    input  logic       i_next,
    input  logic       i_bit,
    output logic [6:0] o_crc7
);

    logic feedback;

    // Polynomial x^7 + x^3 + 1
    assign feedback = i_bit ^ o_crc7[6];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_crc7 <= '0;
        end else if (i_clear) begin
            o_crc7 <= '0;
        end else if (i_next) begin
            o_crc7 <= {o_crc7[5:3], o_crc7[2] ^ feedback, o_crc7[1:0], feedback};
        end
    end

endmodule

//--- source/sd_cmd_trx.sv
// SD command line engine
`timescale 1ns/1ps

module sd_cmd_trx import sd_pkg::*; #(
    parameter int WATCHDOG = 64
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_sclk_rise,
    input  logic        i_sclk_fall,
    input  logic        i_req_valid,
    input  sd_cmd_req_t i_req,
    input  logic        i_cmd,
    input  logic [6:0]  i_crc7,
    output logic        o_done,
    output sd_cmd_rsp_t o_rsp,
    output logic        o_cmd,
    output logic        o_cmd_dir,
    output logic        o_crc_clear,
    output logic        o_crc_next,
    output logic        o_crc_bit
);

    localparam int WDW = $clog2(WATCHDOG + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SEND,
        ST_TURN,
        ST_WAIT,
        ST_RECV,
        ST_DONE
    } trx_state_e;

    trx_state_e     state;
    logic [7:0]     bit_cnt;
    logic [WDW-1:0] wdog;
    logic [38:0]    rx_sr;
    logic [5:0]     rx_index;
    logic [39:0]    tx_frame;
    logic           tx_bit;
    logic [7:0]     rx_last;
    logic           start_tx;
    logic           rx_end;
    logic           wd_expire;
    logic           crc_checked;
    sd_cmderr_e     rx_err;

    // Start bit, transmission bit, index and argument
    assign tx_frame = {1'b0, 1'b1, i_req.cmd, i_req.arg};

    always_comb begin
        if (bit_cnt < 8'd40) begin
            tx_bit = tx_frame[39 - bit_cnt];
        end else if (bit_cnt < 8'd47) begin
            tx_bit = i_crc7[46 - bit_cnt];
        end else begin
            tx_bit = 1'b1;
        end
    end

    assign rx_last     = (i_req.rsp == R2) ? 8'(SD_R2_BITS - 1) : 8'(SD_CMD_BITS - 1);
    assign start_tx    = (state == ST_IDLE) && i_req_valid && i_sclk_fall;
    assign rx_end      = (state == ST_RECV) && i_sclk_rise && (bit_cnt == rx_last);
    assign wd_expire   = (state == ST_WAIT) && i_sclk_rise && i_cmd &&
                         (wdog == WDW'(WATCHDOG - 1));
    assign crc_checked = (i_req.rsp == R1) || (i_req.rsp == R6) || (i_req.rsp == R7);

    // R2 and R3 carry no usable index or CRC
    always_comb begin
        if (crc_checked && (rx_sr[6:0] != i_crc7)) begin
            rx_err = CMDERR_BAD_CRC;
        end else if (crc_checked && (rx_index != i_req.cmd)) begin
            rx_err = CMDERR_BAD_INDEX;
        end else begin
            rx_err = CMDERR_NONE;
        end
    end

    // CRC covers the first 40 bits in both directions
    assign o_crc_clear = ((state == ST_IDLE) && !start_tx) || (state == ST_TURN);
    assign o_crc_next  = start_tx ||
                         ((state == ST_SEND) && i_sclk_fall && (bit_cnt < 8'd40)) ||
                         ((state == ST_WAIT) && i_sclk_rise && !i_cmd) ||
                         ((state == ST_RECV) && i_sclk_rise && (bit_cnt < 8'd40));
    assign o_crc_bit   = ((state == ST_WAIT) || (state == ST_RECV)) ? i_cmd : tx_bit;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state     <= ST_IDLE;
            bit_cnt   <= '0;
            wdog      <= '0;
            o_done    <= 1'b0;
            o_cmd     <= 1'b1;
            o_cmd_dir <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_tx) begin
                        o_cmd   <= tx_bit;
                        bit_cnt <= 8'd1;
                        state   <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (i_sclk_fall) begin
                        o_cmd   <= tx_bit;
                        bit_cnt <= bit_cnt + 8'd1;
                        if (bit_cnt == 8'(SD_CMD_BITS - 1)) begin
                            state <= ST_TURN;
                        end
                    end
                end
                ST_TURN: begin
                    // Release the line one SD clock after the end bit
                    if (i_sclk_fall) begin
                        o_cmd     <= 1'b1;
                        o_cmd_dir <= 1'b1;
                        wdog      <= '0;
                        bit_cnt   <= '0;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (i_sclk_rise) begin
                        if (!i_cmd) begin
                            bit_cnt <= 8'd1;
                            state   <= ST_RECV;
                        end else if (wd_expire) begin
                            o_cmd_dir <= 1'b0;
                            o_done    <= 1'b1;
                            state     <= ST_DONE;
                        end else begin
                            wdog <= wdog + 1'b1;
                        end
                    end
                end
                ST_RECV: begin
                    if (rx_end) begin
                        o_cmd_dir <= 1'b0;
                        o_done    <= 1'b1;
                        bit_cnt   <= '0;
                        state     <= ST_DONE;
                    end else if (i_sclk_rise) begin
                        bit_cnt <= bit_cnt + 8'd1;
                    end
                end
                ST_DONE: begin
                    if (!i_req_valid) begin
                        o_done <= 1'b0;
                        state  <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Response shift register and result capture
    always_ff @(posedge i_clk) begin
        if (((state == ST_WAIT) || (state == ST_RECV)) && i_sclk_rise) begin
            rx_sr <= {rx_sr[37:0], i_cmd};
        end
        if ((state == ST_RECV) && i_sclk_rise && (bit_cnt == 8'd7)) begin
            rx_index <= {rx_sr[4:0], i_cmd};
        end
        if (rx_end) begin
            // End bit still on the line, so the register sits at 38..7
            o_rsp.index  <= rx_index;
            o_rsp.regval <= rx_sr[38:7];
            o_rsp.err    <= rx_err;
            o_rsp.busy_n <= rx_sr[38];
            o_rsp.spare  <= 2'b00;
        end else if (wd_expire) begin
            o_rsp.index  <= '0;
            o_rsp.regval <= '0;
            o_rsp.err    <= CMDERR_NO_RESPONSE;
            o_rsp.busy_n <= 1'b0;
            o_rsp.spare  <= 2'b00;
        end
    end

endmodule

//--- source/sd_init_fsm.sv
// Card initialization sequencer
`timescale 1ns/1ps

module sd_init_fsm import sd_pkg::*; #(
    parameter logic [3:0] VHS           = 4'h1,
    parameter logic [7:0] CHECK_PATTERN = 8'hAA
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_init_req,
    input  logic        i_sclk_rise,
    input  logic        i_cmd_done,
    input  sd_cmd_rsp_t i_cmd_rsp,
    output logic        o_init_ack,
    output logic        o_cmd_req_valid,
    output sd_cmd_req_t o_cmd_req,
    output sd_state_e   o_sdstate,
    output sd_type_e    o_sdtype,
    output logic [15:0] o_rca,
    output logic [23:0] o_ocr
);

    sd_idle_e   idle_step;
    logic [6:0] clk_cnt;
    // Host capacity support sent in ACMD41
    logic       hcs;
    // Card capacity status from the last ACMD41 reply
    logic       ccs;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_sdstate       <= SDSTATE_PRE_INIT;
            idle_step       <= IDLE_CMD0;
            clk_cnt         <= '0;
            hcs             <= 1'b1;
            ccs             <= 1'b0;
            o_init_ack      <= 1'b0;
            o_cmd_req_valid <= 1'b0;
            o_cmd_req       <= '{cmd: CMD0, arg: 32'd0, rsp: R1};
            o_sdtype        <= SDCARD_UNKNOWN;
            o_rca           <= '0;
            o_ocr           <= 24'hFF8000;
        end else if (o_cmd_req_valid) begin
            if (i_cmd_done) begin
                o_cmd_req_valid <= 1'b0;
                if (i_cmd_rsp.err != CMDERR_NONE) begin
                    if ((o_cmd_req.cmd == CMD8) && (i_cmd_rsp.err == CMDERR_NO_RESPONSE)) begin
                        // Version 1.x card ignores CMD8
                        o_sdtype  <= SDCARD_VER1X;
                        hcs       <= 1'b0;
                        idle_step <= IDLE_CMD55;
                    end else if (o_cmd_req.cmd == CMD0) begin
                        idle_step <= IDLE_CMD0;
                    end else begin
                        o_sdstate <= SDSTATE_INA;
                        o_sdtype  <= SDCARD_UNUSABLE;
                    end
                end else begin
                    case (o_cmd_req.cmd)
                        CMD0:  idle_step <= IDLE_CMD8;
                        CMD8:  idle_step <= IDLE_CMD55;
                        CMD55: idle_step <= IDLE_ACMD41;
                        ACMD41: begin
                            o_ocr     <= i_cmd_rsp.regval[23:0];
                            ccs       <= i_cmd_rsp.regval[30];
                            idle_step <= i_cmd_rsp.busy_n ? IDLE_CARD_ID : IDLE_CMD55;
                        end
                        CMD2: o_sdstate <= SDSTATE_IDENT;
                        CMD3: begin
                            o_rca     <= i_cmd_rsp.regval[31:16];
                            o_sdstate <= SDSTATE_STBY;
                        end
                        default: o_sdstate <= SDSTATE_INA;
                    endcase
                end
            end
        end else if (!i_cmd_done) begin
            // New commands wait until the engine has dropped done
            case (o_sdstate)
                SDSTATE_PRE_INIT: begin
                    if (i_init_req && i_sclk_rise) begin
                        clk_cnt <= clk_cnt + 7'd1;
                    end
                    if (clk_cnt == 7'(SD_PREINIT_CLKS)) begin
                        clk_cnt   <= '0;
                        idle_step <= IDLE_CMD0;
                        o_sdstate <= SDSTATE_IDLE;
                    end
                end
                SDSTATE_IDLE: begin
                    case (idle_step)
                        IDLE_CMD0: begin
                            o_sdtype        <= SDCARD_UNKNOWN;
                            hcs             <= 1'b1;
                            ccs             <= 1'b0;
                            o_ocr           <= 24'hFF8000;
                            o_rca           <= '0;
                            o_cmd_req       <= '{cmd: CMD0, arg: 32'd0, rsp: R1};
                            o_cmd_req_valid <= 1'b1;
                        end
                        IDLE_CMD8: begin
                            o_cmd_req <= '{cmd: CMD8, arg: {20'd0, VHS, CHECK_PATTERN}, rsp: R7};
                            o_cmd_req_valid <= 1'b1;
                        end
                        IDLE_CMD55: begin
                            o_cmd_req       <= '{cmd: CMD55, arg: 32'd0, rsp: R1};
                            o_cmd_req_valid <= 1'b1;
                        end
                        IDLE_ACMD41: begin
                            o_cmd_req <= '{cmd: ACMD41, arg: {1'b0, hcs, 6'd0, o_ocr}, rsp: R3};
                            o_cmd_req_valid <= 1'b1;
                        end
                        IDLE_CARD_ID: begin
                            if (ccs) begin
                                o_sdtype <= SDCARD_VER2X_HC;
                            end else if (o_sdtype != SDCARD_VER1X) begin
                                o_sdtype <= SDCARD_VER2X_SC;
                            end
                            o_sdstate <= SDSTATE_READY;
                        end
                        default: idle_step <= IDLE_CMD0;
                    endcase
                end
                SDSTATE_READY: begin
                    o_cmd_req       <= '{cmd: CMD2, arg: 32'd0, rsp: R2};
                    o_cmd_req_valid <= 1'b1;
                end
                SDSTATE_IDENT: begin
                    o_cmd_req       <= '{cmd: CMD3, arg: 32'd0, rsp: R6};
                    o_cmd_req_valid <= 1'b1;
                end
                SDSTATE_STBY, SDSTATE_INA: begin
                    // Host handshake closes the sequence
                    if (i_init_req && !o_init_ack) begin
                        o_init_ack <= 1'b1;
                    end else if (!i_init_req && o_init_ack) begin
                        o_init_ack <= 1'b0;
                        o_sdstate  <= SDSTATE_PRE_INIT;
                    end
                end
                default: o_sdstate <= SDSTATE_PRE_INIT;
            endcase
        end
    end

endmodule

//--- source/sd_ctrl_top.sv
// SD card init controller top
`timescale 1ns/1ps

module sd_ctrl_top import sd_pkg::*; #(
    parameter int         CLK_DIV       = 2,
    parameter int         WATCHDOG      = 64,
    parameter logic [3:0] VHS           = 4'h1,
    parameter logic [7:0] CHECK_PATTERN = 8'hAA
) (
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_init_req,
    input  logic        i_cmd,
    output logic        o_sclk,
    output logic        o_cmd,
    output logic        o_cmd_dir,
    output logic        o_init_ack,
    output sd_state_e   o_sdstate,
    output sd_type_e    o_sdtype,
    output logic [15:0] o_rca,
    output logic [23:0] o_ocr
);

    logic        sclk_rise;
    logic        sclk_fall;
    logic        crc_clear;
    logic        crc_next;
    logic        crc_bit;
    logic [6:0]  crc7;
    logic        cmd_req_valid;
    logic        cmd_done;
    sd_cmd_req_t cmd_req;
    sd_cmd_rsp_t cmd_rsp;

    sd_clk_gen #(
        .CLK_DIV(CLK_DIV)
    ) u_clk_gen (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .o_sclk      (o_sclk),
        .o_sclk_rise (sclk_rise),
        .o_sclk_fall (sclk_fall)
    );

    sd_crc7 u_crc7 (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_clear (crc_clear),
        .i_next  (crc_next),
        .i_bit   (crc_bit),
        .o_crc7  (crc7)
    );

    sd_cmd_trx #(
        .WATCHDOG(WATCHDOG)
    ) u_cmd_trx (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_sclk_rise (sclk_rise),
        .i_sclk_fall (sclk_fall),
        .i_req_valid (cmd_req_valid),
        .i_req       (cmd_req),
        .i_cmd       (i_cmd),
        .i_crc7      (crc7),
        .o_done      (cmd_done),
        .o_rsp       (cmd_rsp),
        .o_cmd       (o_cmd),
        .o_cmd_dir   (o_cmd_dir),
        .o_crc_clear (crc_clear),
        .o_crc_next  (crc_next),
        .o_crc_bit   (crc_bit)
    );

    sd_init_fsm #(
        .VHS           (VHS),
        .CHECK_PATTERN (CHECK_PATTERN)
    ) u_init_fsm (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_init_req      (i_init_req),
        .i_sclk_rise     (sclk_rise),
        .i_cmd_done      (cmd_done),
        .i_cmd_rsp       (cmd_rsp),
        .o_init_ack      (o_init_ack),
        .o_cmd_req_valid (cmd_req_valid),
        .o_cmd_req       (cmd_req),
        .o_sdstate       (o_sdstate),
        .o_sdtype        (o_sdtype),
        .o_rca           (o_rca),
        .o_ocr           (o_ocr)
    );

endmodule

//--- tb/sd_ctrl_sva.sv
// Handshake and CMD line assertions
`timescale 1ns/1ps

module sd_ctrl_sva import sd_pkg::*; (
    input logic        i_clk,
    input logic        i_nrst,
    input logic        i_init_req,
    input logic        i_init_ack,
    input logic        i_cmd_line,
    input logic        i_cmd_dir,
    input logic        i_req_valid,
    input logic        i_cmd_done,
    input sd_cmd_req_t i_req
);

    int fail_cnt = 0;

    ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $rose(i_init_ack) |-> $past(i_init_req))
    else begin
        fail_cnt++;
        $error("o_init_ack rose without i_init_req");
    end

    ack_drop_after_req: assert property (@(posedge i_clk) disable iff (!i_nrst)
        $fell(i_init_ack) |-> !$past(i_init_req))
    else begin
        fail_cnt++;
        $error("o_init_ack fell while i_init_req was still high");
    end

    // Idle output line stays at one
    cmd_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (!i_cmd_dir && !i_req_valid && !i_cmd_done) |-> i_cmd_line)
    else begin
        fail_cnt++;
        $error("CMD line low with no command active");
    end

    req_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_req_valid && $past(i_req_valid)) |-> $stable(i_req))
    else begin
        fail_cnt++;
        $error("Command request changed while valid");
    end

endmodule

bind sd_ctrl_top sd_ctrl_sva u_sva (
    .i_clk       (i_clk),
    .i_nrst      (i_nrst),
    .i_init_req  (i_init_req),
    .i_init_ack  (o_init_ack),
    .i_cmd_line  (o_cmd),
    .i_cmd_dir   (o_cmd_dir),
    .i_req_valid (cmd_req_valid),
    .i_cmd_done  (cmd_done),
    .i_req       (cmd_req)
);

//--- tb/sd_card_model.sv
// Behavioral SD card on the command line
`timescale 1ns/1ps

module sd_card_model (
    input  logic        i_sclk,
    input  logic        i_cmd_line,
    input  logic        i_cmd_dir,
    input  logic        i_cmd8_silent,
    input  logic        i_bad_crc3,
    input  logic        i_ocr_hc,
    input  logic [1:0]  i_busy_cnt,
    input  logic [15:0] i_rca,
    input  logic [23:0] i_ocr_win,
    output logic        o_cmd
);

    localparam logic [127:0] CID = 128'h0353_4453_4430_3847_8012_3456_7801_2345;

    logic        line;
    logic [47:0] rx_frame;
    // Every command frame seen on the line, in order
    logic [47:0] log_frame [0:255];
    int          log_cnt;
    int          acmd41_cnt;

    // Card drives only after the host has turned the line around
    assign o_cmd = i_cmd_dir ? line : 1'b1;

    initial begin
        line       = 1'b1;
        log_cnt    = 0;
        acmd41_cnt = 0;
    end

    task automatic send_bits(input logic [135:0] bits, input int len);
        // NCR gap before the start bit
        repeat (2) @(negedge i_sclk);
        for (int i = len - 1; i >= 0; i--) begin
            @(negedge i_sclk);
            line = bits[i];
        end
        @(negedge i_sclk);
        line = 1'b1;
    endtask

    // Short response with CRC7, optionally corrupted
    task automatic send_r48(input logic [39:0] head, input logic corrupt);
        logic [6:0] crc;
        crc = tb_sd_ctrl.crc7_ref(head) ^ {6'd0, corrupt};
        send_bits({88'd0, head, crc, 1'b1}, 48);
    endtask

    task automatic respond(input logic [5:0] idx, input logic [31:0] arg);
        logic ready;
        case (idx)
            6'd0, 6'd55: begin
                send_r48({2'b00, idx, 32'h0000_0120}, 1'b0);
            end
            6'd8: begin
                // Echo of voltage and check pattern
                if (!i_cmd8_silent) begin
                    send_r48({2'b00, idx, 20'd0, arg[11:0]}, 1'b0);
                end
            end
            6'd41: begin
                ready = (acmd41_cnt >= i_busy_cnt);
                acmd41_cnt++;
                send_bits({88'd0, 2'b00, 6'h3F, ready, i_ocr_hc, 6'd0, i_ocr_win,
                           7'h7F, 1'b1}, 48);
            end
            6'd2: begin
                send_bits({2'b00, 6'h3F, CID[127:1], 1'b1}, 136);
            end
            6'd3: begin
                send_r48({2'b00, idx, i_rca, 16'h0500}, i_bad_crc3);
            end
            default: begin
                line = 1'b1;
            end
        endcase
    endtask

    always begin
        @(posedge i_sclk);
        if (!i_cmd_dir && !i_cmd_line) begin
            rx_frame[47] = 1'b0;
            for (int k = 46; k >= 0; k--) begin
                @(posedge i_sclk);
                rx_frame[k] = i_cmd_line;
            end
            if (log_cnt < 256) begin
                log_frame[log_cnt] = rx_frame;
                log_cnt++;
            end
            // CMD0 restarts the power-up count
            if (rx_frame[45:40] == 6'd0) begin
                acmd41_cnt = 0;
            end
            respond(rx_frame[45:40], rx_frame[39:8]);
        end
    end

endmodule

//--- tb/tb_sd_ctrl.sv
// SD init controller testbench
`timescale 1ns/1ps

module tb_sd_ctrl import sd_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 60000;

    logic        clk;
    logic        nrst;
    logic        init_req;
    logic        card_cmd;
    logic        sclk;
    logic        host_cmd;
    logic        cmd_dir;
    logic        init_ack;
    sd_state_e   sdstate;
    sd_type_e    sdtype;
    logic [15:0] rca;
    logic [23:0] ocr;

    // Card model knobs
    logic        cmd8_silent;
    logic        bad_crc3;
    logic        ocr_hc;
    logic [1:0]  busy_cnt;
    logic [15:0] card_rca;
    logic [23:0] ocr_win;

    logic [31:0] lfsr_state;
    int          pre_cnt;
    logic        start_seen;
    logic        sclk_q;

    sd_ctrl_top #(
        .CLK_DIV       (2),
        .WATCHDOG      (64),
        .VHS           (4'h1),
        .CHECK_PATTERN (8'hAA)
    ) i_dut (
        .i_clk      (clk),
        .i_nrst     (nrst),
        .i_init_req (init_req),
        .i_cmd      (card_cmd),
        .o_sclk     (sclk),
        .o_cmd      (host_cmd),
        .o_cmd_dir  (cmd_dir),
        .o_init_ack (init_ack),
        .o_sdstate  (sdstate),
        .o_sdtype   (sdtype),
        .o_rca      (rca),
        .o_ocr      (ocr)
    );

    sd_card_model u_card (
        .i_sclk        (sclk),
        .i_cmd_line    (host_cmd),
        .i_cmd_dir     (cmd_dir),
        .i_cmd8_silent (cmd8_silent),
        .i_bad_crc3    (bad_crc3),
        .i_ocr_hc      (ocr_hc),
        .i_busy_cnt    (busy_cnt),
        .i_rca         (card_rca),
        .i_ocr_win     (ocr_win),
        .o_cmd         (card_cmd)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [6:0] crc7_ref(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    function automatic sd_type_e expected_type(input logic silent, input logic bad3,
                                               input logic hc);
        if (bad3) begin
            return SDCARD_UNUSABLE;
        end else if (hc) begin
            return SDCARD_VER2X_HC;
        end else if (silent) begin
            return SDCARD_VER1X;
        end
        return SDCARD_VER2X_SC;
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            fail_stop($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp_v, act_v));
        end
    endtask

    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_stop($sformatf("Timed out waiting for o_init_ack to become %0d", level));
            end
        end while (init_ack !== level);
    endtask

    // SD clock rising edges between request and first start bit
    always @(negedge clk) begin
        if (!init_req) begin
            pre_cnt    <= 0;
            start_seen <= 1'b0;
        end else if (!start_seen) begin
            if (!cmd_dir && !host_cmd) begin
                start_seen <= 1'b1;
            end else if (sclk && !sclk_q) begin
                pre_cnt <= pre_cnt + 1;
            end
        end
        sclk_q <= sclk;
    end

    // Bound checker failures end the run at once
    always @(negedge clk) begin
        if (i_dut.u_sva.fail_cnt != 0) begin
            fail_stop($sformatf("Bound assertion failed, %0d failures so far",
                                i_dut.u_sva.fail_cnt));
        end
    end

    task automatic run_sequence(input string name, input logic silent, input logic bad3,
                                input logic hc, input logic [23:0] win);
        logic [31:0] r;
        logic [31:0] arg;
        logic [47:0] f;
        logic [5:0]  exp_idx;
        int          base;
        int          n_exp;
        rand_bits(16, r);
        @(posedge clk);
        card_rca    <= r[15:0];
        cmd8_silent <= silent;
        bad_crc3    <= bad3;
        ocr_hc      <= hc;
        ocr_win     <= win;
        rand_bits(2, r);
        busy_cnt    <= r[1:0];
        n_exp = 4 + 2 * (r[1:0] + 1);
        base  = u_card.log_cnt;
        init_req <= 1'b1;
        wait_ack(1'b1);
        check_value({name, " preinit_clocks_ge_74"}, 1, pre_cnt >= 74);
        check_value({name, " state"}, bad3 ? SDSTATE_INA : SDSTATE_STBY, sdstate);
        check_value({name, " type"}, expected_type(silent, bad3, hc), sdtype);
        check_value({name, " ocr"}, win, ocr);
        if (!bad3) begin
            check_value({name, " rca"}, card_rca, rca);
        end
        check_value({name, " command_count"}, n_exp, u_card.log_cnt - base);
        for (int i = 0; i < n_exp; i++) begin
            f   = u_card.log_frame[base + i];
            arg = f[39:8];
            if (i == 0) begin
                exp_idx = CMD0;
            end else if (i == 1) begin
                exp_idx = CMD8;
            end else if (i == n_exp - 2) begin
                exp_idx = CMD2;
            end else if (i == n_exp - 1) begin
                exp_idx = CMD3;
            end else begin
                exp_idx = (i % 2 == 0) ? CMD55 : ACMD41;
            end
            check_value($sformatf("%s cmd%0d index", name, i), exp_idx, f[45:40]);
            check_value($sformatf("%s cmd%0d start", name, i), 2'b01, f[47:46]);
            check_value($sformatf("%s cmd%0d crc7", name, i), crc7_ref(f[47:8]), f[7:1]);
            check_value($sformatf("%s cmd%0d end_bit", name, i), 1, f[0]);
            if (exp_idx == CMD8) begin
                check_value({name, " cmd8_arg"}, 32'h0000_01AA, arg);
            end
            if (exp_idx == ACMD41) begin
                check_value($sformatf("%s acmd41_hcs%0d", name, i), !silent, arg[30]);
            end
        end
        @(posedge clk);
        init_req <= 1'b0;
        wait_ack(1'b0);
        check_value({name, " state_after_release"}, SDSTATE_PRE_INIT, sdstate);
    endtask

    initial begin
        nrst        = 1'b0;
        init_req    = 1'b0;
        cmd8_silent = 1'b0;
        bad_crc3    = 1'b0;
        ocr_hc      = 1'b0;
        busy_cnt    = 2'd0;
        card_rca    = 16'd0;
        ocr_win     = 24'hFF8000;
        lfsr_state  = 32'h9211_2caa;
        repeat (3) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        check_value("reset ack", 0, init_ack);
        check_value("reset cmd_line", 1, host_cmd);
        check_value("reset cmd_dir", 0, cmd_dir);
        run_sequence("sc_card", 1'b0, 1'b0, 1'b0, 24'hFF8000);
        run_sequence("hc_card", 1'b0, 1'b0, 1'b1, 24'h3C0000);
        run_sequence("v1_card", 1'b1, 1'b0, 1'b0, 24'hFF8000);
        run_sequence("bad_cmd3_crc", 1'b0, 1'b1, 1'b0, 24'h1F8000);
        // Second request on a working card after a failed one
        run_sequence("repeat_sc_card", 1'b0, 1'b0, 1'b0, 24'hFF8000);
        if (i_dut.u_sva.fail_cnt == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_stop($sformatf("Assertion failures: %0d", i_dut.u_sva.fail_cnt));
        end
    end

endmodule

//--- list.f
source/sd_pkg.sv
source/sd_clk_gen.sv
source/sd_crc7.sv
source/sd_cmd_trx.sv
source/sd_init_fsm.sv
source/sd_ctrl_top.sv
tb/sd_ctrl_sva.sv
tb/sd_card_model.sv
tb/tb_sd_ctrl.sv
